/* tests/memoryTests.mem */
// sel addr wdata readMode writeMode unsigned expReadData ioCheck expDisplay expResetAddr
// Modes 0 none, 1 byte, 2 half, 3 word; a line starting with ff ends the list
1 0ff 00000000 3 0 0 00000000 1 00000000 000003fc
1 103 00000000 3 0 0 000003fc 1 00000000 000003fc
// RAM words, back to back
1 400 11223344 0 3 0 00000000 0 00000000 00000000
1 400 00000000 3 0 0 11223344 0 00000000 00000000
1 404 a5b6c7d8 0 3 0 00000000 0 00000000 00000000
1 404 00000000 3 0 0 a5b6c7d8 0 00000000 00000000
1 408 8899aabb 0 3 0 00000000 0 00000000 00000000
1 400 00000000 3 0 0 11223344 0 00000000 00000000
1 400 cafef00d 0 3 0 00000000 0 00000000 00000000
1 400 00000000 3 0 0 cafef00d 0 00000000 00000000
1 408 00000000 3 0 0 8899aabb 0 00000000 00000000
// Byte and halfword lanes
1 40c 12345678 0 3 0 00000000 0 00000000 00000000
1 40d 000000f0 0 1 0 00000000 0 00000000 00000000
1 40c 00000000 3 0 0 1234f078 0 00000000 00000000
1 40d 00000000 1 0 0 fffffff0 0 00000000 00000000
1 40d 00000000 1 0 1 000000f0 0 00000000 00000000
1 40c 00000000 1 0 0 00000078 0 00000000 00000000
1 40e 00008001 0 2 0 00000000 0 00000000 00000000
1 40c 00000000 3 0 0 8001f078 0 00000000 00000000
1 40e 00000000 2 0 0 ffff8001 0 00000000 00000000
1 40e 00000000 2 0 1 00008001 0 00000000 00000000
1 40f 00000000 2 0 0 ffff8001 0 00000000 00000000
1 40d 0000beef 0 2 0 00000000 0 00000000 00000000
1 40c 00000000 2 0 1 0000beef 0 00000000 00000000
1 40f 00000000 1 0 0 ffffff80 0 00000000 00000000
1 40e 00000000 1 0 1 00000001 0 00000000 00000000
1 40f 0000007f 0 1 0 00000000 0 00000000 00000000
1 40c 00000000 3 0 0 7f01beef 0 00000000 00000000
1 800 00000000 3 0 0 cafef00d 0 00000000 00000000
// Display and reset-address registers
1 0ff 00000c3f 0 3 0 00000000 1 00000c3f 000003fc
1 0ff 00000000 3 0 0 00000c3f 1 00000c3f 000003fc
1 103 00001000 0 1 0 00000000 1 00000c3f 00001000
1 103 00000000 1 0 0 00001000 1 00000c3f 00001000
1 103 00000000 3 0 1 00001000 0 00000000 00000000
// Unmapped addresses
1 000 00000000 3 0 0 00000000 0 00000000 00000000
1 0fe 00000000 3 0 0 00000000 0 00000000 00000000
1 107 00000000 3 0 0 00000000 0 00000000 00000000
1 258 00000000 3 0 0 00000000 0 00000000 00000000
1 107 ffffffff 0 3 0 00000000 1 00000c3f 00001000
1 258 12341234 0 3 0 00000000 1 00000c3f 00001000
1 000 55555555 0 3 0 00000000 1 00000c3f 00001000
1 0ff 00000000 3 0 0 00000c3f 1 00000c3f 00001000
1 103 00000000 3 0 0 00001000 1 00000c3f 00001000
1 400 00000000 3 0 0 cafef00d 0 00000000 00000000
// Select low and modeNone reads
0 400 deadbeef 0 3 0 00000000 0 00000000 00000000
0 0ff 0000dead 0 3 0 00000000 1 00000c3f 00001000
0 400 00000000 3 0 0 00000000 0 00000000 00000000
1 400 00000000 3 0 0 cafef00d 0 00000000 00000000
1 400 00000000 0 0 0 00000000 0 00000000 00000000
1 0ff 00000000 0 0 0 00000000 0 00000000 00000000
0 103 00000000 3 0 0 00000000 1 00000c3f 00001000
1 103 00000000 3 0 0 00001000 1 00000c3f 00001000
ff 000 00000000 0 0 0 00000000 0 00000000 00000000

/* compile.f */
src/memoryPkg.sv
src/memoryBus.sv
src/addressDecoder.sv
src/dataMemory.sv
src/ioRegisters.sv
src/memorySystem.sv
tests/clockGen.sv
tests/memorySystemTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module memorySystemTb \
	-f compile.f -o simv || exit 1
output=$(./obj_dir/simv) && echo "$output" && echo "$output" | grep -qx "Test OK" || exit 1

/* tests/memorySystemTb.sv */
`timescale 1ns/1ps

module memorySystemTb;
	import memoryPkg::*;

	// Columns per vector line in the data file
	localparam int fieldCount = 10;
	localparam int maxVectors = 64;
	localparam int ramDepth = 256;

	logic clk;
	logic rst;
	logic externalSelect;
	word_t address;
	word_t writeData;
	accessMode_t readMode;
	accessMode_t writeMode;
	logic unsignedLoad;
	word_t readData;
	word_t sevenSegmentDisplay;
	word_t resetAddress;

	word_t vectors [maxVectors * fieldCount];
	int vectorCount;
	int errorCount;
	int checkCount;
	int cycleCount = 0;
	int cycleLimit = 0;

	clockGen clocks (
		.clk(clk),
		.rst(rst)
	);

	memorySystem #(
		.ramWords(ramDepth)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.externalSelect(externalSelect),
		.address(address),
		.writeData(writeData),
		.readMode(readMode),
		.writeMode(writeMode),
		.unsignedLoad(unsignedLoad),
		.readData(readData),
		.sevenSegmentDisplay(sevenSegmentDisplay),
		.resetAddress(resetAddress)
	);

	// Request fields of one vector onto the DUT inputs
	task automatic driveVector(input int line);
		int base;
		base = line * fieldCount;
		externalSelect <= vectors[base][0];
		address <= vectors[base + 1];
		writeData <= vectors[base + 2];
		readMode <= accessMode_t'(vectors[base + 3][2:0]);
		writeMode <= accessMode_t'(vectors[base + 4][2:0]);
		unsignedLoad <= vectors[base + 5][0];
	endtask

	task automatic driveIdle();
		externalSelect <= 1'b0;
		address <= '0;
		writeData <= '0;
		readMode <= modeNone;
		writeMode <= modeNone;
		unsignedLoad <= 1'b0;
	endtask

	// Response to a vector whose request edge has just passed
	task automatic checkResponse(input int line);
		int base;
		base = line * fieldCount;
		checkCount++;
		if (readData !== vectors[base + 6]) begin
			errorCount++;
			$display("ERROR readData vector %0d expected %08h actual %08h",
				line, vectors[base + 6], readData);
		end
		// Display and reset address only on marked lines
		if (vectors[base + 7] != 32'd0) begin
			checkCount += 2;
			if (sevenSegmentDisplay !== vectors[base + 8]) begin
				errorCount++;
				$display("ERROR sevenSegmentDisplay vector %0d expected %08h actual %08h",
					line, vectors[base + 8], sevenSegmentDisplay);
			end
			if (resetAddress !== vectors[base + 9]) begin
				errorCount++;
				$display("ERROR resetAddress vector %0d expected %08h actual %08h",
					line, vectors[base + 9], resetAddress);
			end
		end
	endtask

	// Watchdog
	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		driveIdle();
		errorCount = 0;
		checkCount = 0;
		vectorCount = 0;
		$readmemh("tests/memoryTests.mem", vectors);

		// A first field of ff marks the end of the list
		while (vectorCount < maxVectors && vectors[vectorCount * fieldCount] != 32'hFF) begin
			vectorCount++;
		end
		if (vectorCount == 0) begin
			errorCount++;
			$display("No test vectors were read from the data file");
		end
		cycleLimit = vectorCount + 20;

		wait (rst === 1'b1);
		for (int line = 0; line < vectorCount; line++) begin
			@(posedge clk);
			driveVector(line);
			@(negedge clk);
			if (line > 0) begin
				checkResponse(line - 1);
			end
		end
		@(posedge clk);
		driveIdle();
		@(negedge clk);
		if (vectorCount > 0) begin
			checkResponse(vectorCount - 1);
		end

		$display("Vectors: %0d, checks: %0d, errors: %0d", vectorCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* tests/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
	parameter int halfPeriod = 20,
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Released on a falling edge, clear of the rising edges
	initial begin
		rst = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
	end

endmodule

/* src/memorySystem.sv */
`timescale 1ns/1ps

module memorySystem #(
	parameter int ramWords = 256
) (
	input logic clk,
	input logic rst,
	input logic externalSelect,
	input memoryPkg::word_t address,
	input memoryPkg::word_t writeData,
	input memoryPkg::accessMode_t readMode,
	input memoryPkg::accessMode_t writeMode,
	input logic unsignedLoad,
	output memoryPkg::word_t readData,
	output memoryPkg::word_t sevenSegmentDisplay,
	output memoryPkg::word_t resetAddress
);

	// One bus per target
	memoryBus ramBus ();
	memoryBus ioBus ();

	addressDecoder #(
		.ramWords(ramWords)
	) decoder (
		.clk(clk),
		.rst(rst),
		.externalSelect(externalSelect),
		.address(address),
		.writeData(writeData),
		.readMode(readMode),
		.writeMode(writeMode),
		.unsignedLoad(unsignedLoad),
		.readData(readData),
		.ramBus(ramBus),
		.ioBus(ioBus)
	);

	dataMemory #(
		.ramWords(ramWords)
	) dataRam (
		.clk(clk),
		.rst(rst),
		.bus(ramBus)
	);

	ioRegisters ioRegs (
		.clk(clk),
		.rst(rst),
		.bus(ioBus),
		.sevenSegmentDisplay(sevenSegmentDisplay),
		.resetAddress(resetAddress)
	);

endmodule

/* src/ioRegisters.sv */
`timescale 1ns/1ps

module ioRegisters (
	input logic clk,
	input logic rst,
	memoryBus.target bus,
	output memoryPkg::word_t sevenSegmentDisplay,
	output memoryPkg::word_t resetAddress
);
	import memoryPkg::*;

	logic writing;

	// Read request held from the request edge
	word_t readAddrReg;
	accessMode_t readModeReg;

	// Any width stores the whole word
	always_comb begin
		writing = (bus.writeMode != modeNone);
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sevenSegmentDisplay <= '0;
			resetAddress <= resetAddrDefault;
			readModeReg <= modeNone;
		end else begin
			if (writing && bus.address == displayAddr) begin
				sevenSegmentDisplay <= bus.data;
			end
			if (writing && bus.address == resetAddrAddr) begin
				resetAddress <= bus.data;
			end
			readModeReg <= bus.readMode;
		end
	end

	always_ff @(posedge clk) begin
		readAddrReg <= bus.address;
	end

	always_comb begin
		bus.readValue = '0;
		if (readModeReg != modeNone) begin
			if (readAddrReg == displayAddr) begin
				bus.readValue = sevenSegmentDisplay;
			end else if (readAddrReg == resetAddrAddr) begin
				bus.readValue = resetAddress;
			end
		end
	end

endmodule

/* src/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory #(
	parameter int ramWords = 256
) (
	input logic clk,
	input logic rst,
	memoryBus.target bus
);
	import memoryPkg::*;

	localparam int indexBits = $clog2(ramWords);

	typedef logic [indexBits-1:0] wordIndex_t;

	// Byte lanes kept little-endian inside each word
	word_t mem [ramWords];

	wordIndex_t requestIndex;
	byteIndex_t requestLane;
	logic [3:0] byteEnable;
	word_t laneData;

	// Read request held from the request edge
	wordIndex_t indexReg;
	byteIndex_t laneReg;
	accessMode_t modeReg;
	logic unsignedReg;

	word_t storedWord;
	logic [7:0] readByte;
	logic [15:0] readHalf;

	always_comb begin
		requestIndex = bus.address[indexBits+1:2];
		requestLane = bus.address[1:0];
		byteEnable = 4'b0000;
		laneData = bus.data;
		case (bus.writeMode)
			modeByte: begin
				byteEnable = 4'b0001 << requestLane;
				laneData = {4{bus.data[7:0]}};
			end
			modeHalf: begin
				// Bit 0 of the address plays no part here
				byteEnable = requestLane[1] ? 4'b1100 : 4'b0011;
				laneData = {2{bus.data[15:0]}};
			end
			modeWord: begin
				byteEnable = 4'b1111;
			end
			default: begin
				byteEnable = 4'b0000;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		for (int lane = 0; lane < 4; lane++) begin
			if (byteEnable[lane]) begin
				mem[requestIndex][8*lane +: 8] <= laneData[8*lane +: 8];
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			modeReg <= modeNone;
			unsignedReg <= 1'b0;
		end else begin
			modeReg <= bus.readMode;
			unsignedReg <= bus.unsignedLoad;
		end
	end

	always_ff @(posedge clk) begin
		indexReg <= requestIndex;
		laneReg <= requestLane;
	end

	// Array read follows the registered index, so a write just made is visible
	always_comb begin
		storedWord = mem[indexReg];
		readByte = storedWord[8*laneReg +: 8];
		readHalf = storedWord[16*laneReg[1] +: 16];
		case (modeReg)
			modeByte: begin
				if (unsignedReg) begin
					bus.readValue = {24'd0, readByte};
				end else begin
					bus.readValue = {{24{readByte[7]}}, readByte};
				end
			end
			modeHalf: begin
				if (unsignedReg) begin
					bus.readValue = {16'd0, readHalf};
				end else begin
					bus.readValue = {{16{readHalf[15]}}, readHalf};
				end
			end
			modeWord: begin
				bus.readValue = storedWord;
			end
			default: begin
				bus.readValue = '0;
			end
		endcase
	end

endmodule

/* src/addressDecoder.sv */
`timescale 1ns/1ps

module addressDecoder #(
	parameter int ramWords = 256
) (
	input logic clk,
	input logic rst,
	input logic externalSelect,
	input memoryPkg::word_t address,
	input memoryPkg::word_t writeData,
	input memoryPkg::accessMode_t readMode,
	input memoryPkg::accessMode_t writeMode,
	input logic unsignedLoad,
	output memoryPkg::word_t readData,
	memoryBus.initiator ramBus,
	memoryBus.initiator ioBus
);
	import memoryPkg::*;

	// Bytes covered by the RAM before addresses wrap around
	localparam word_t ramSpan = word_t'(ramWords * 4);

	logic ramHit;
	logic ioHit;
	word_t ramOffset;

	// Target chosen in the previous cycle
	logic ramSelected;
	logic ioSelected;
	logic selectReg;

	always_comb begin
		ramHit = (address >= ramBaseAddr);
		ioHit = (address == displayAddr) || (address == resetAddrAddr);
		// RAM sees its own offset, folded into its size
		ramOffset = (address - ramBaseAddr) & (ramSpan - 32'd1);
	end

	// RAM request
	always_comb begin
		ramBus.address = '0;
		ramBus.data = '0;
		ramBus.readMode = modeNone;
		ramBus.writeMode = modeNone;
		ramBus.unsignedLoad = 1'b0;
		if (externalSelect && ramHit) begin
			ramBus.address = ramOffset;
			ramBus.data = writeData;
			ramBus.readMode = readMode;
			ramBus.writeMode = writeMode;
			ramBus.unsignedLoad = unsignedLoad;
		end
	end

	// IO request, the registers match on the full address
	always_comb begin
		ioBus.address = '0;
		ioBus.data = '0;
		ioBus.readMode = modeNone;
		ioBus.writeMode = modeNone;
		ioBus.unsignedLoad = 1'b0;
		if (externalSelect && ioHit) begin
			ioBus.address = address;
			ioBus.data = writeData;
			ioBus.readMode = readMode;
			ioBus.writeMode = writeMode;
			ioBus.unsignedLoad = unsignedLoad;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ramSelected <= 1'b0;
			ioSelected <= 1'b0;
			selectReg <= 1'b0;
		end else begin
			ramSelected <= ramHit;
			ioSelected <= ioHit;
			selectReg <= externalSelect;
		end
	end

	// Response mux, unmapped targets read as zero
	always_comb begin
		readData = '0;
		if (selectReg) begin
			if (ramSelected) begin
				readData = ramBus.readValue;
			end else if (ioSelected) begin
				readData = ioBus.readValue;
			end
		end
	end

endmodule

/* src/memoryBus.sv */
`timescale 1ns/1ps

interface memoryBus;
	import memoryPkg::*;

	// Request, already steered by the decoder
	word_t address;
	word_t data;
	accessMode_t readMode;
	accessMode_t writeMode;
	logic unsignedLoad;

	// Response, valid the cycle after the request
	word_t readValue;

	modport initiator (
		output address,
		output data,
		output readMode,
		output writeMode,
		output unsignedLoad,
		input readValue
	);

	modport target (
		input address,
		input data,
		input readMode,
		input writeMode,
		input unsignedLoad,
		output readValue
	);

endinterface

/* src/memoryPkg.sv */
package memoryPkg;

	// Data words and byte addresses share one width
	typedef logic [31:0] word_t;

	// Byte lane inside a word, little-endian
	typedef logic [1:0] byteIndex_t;

	// Access width for reads and writes
	typedef enum logic [2:0] {
		modeNone = 3'd0,
		modeByte = 3'd1,
		modeHalf = 3'd2,
		modeWord = 3'd3
	} accessMode_t;

	// Seven-segment display register
	parameter word_t displayAddr = 32'd255;

	// Start address handed to the processor after reset
	parameter word_t resetAddrAddr = 32'd259;

	// Data RAM occupies everything from here upward
	parameter word_t ramBaseAddr = 32'd1024;

	// Power-on value of the reset-address register
	parameter word_t resetAddrDefault = 32'h3FC;

endpackage
